// File: common/telemetry_consts.svh
`ifndef TELEMETRY_CONSTS_SVH
`define TELEMETRY_CONSTS_SVH

// Word FIFO depth is 2**ABITS entries
`define TELEM_FIFO_ABITS 4

// Words per bulk frame, two bytes each on the stream
`define TELEM_FRAME_WORDS 8

// Bulk-IN endpoint number answered by default
`define TELEM_DEFAULT_ENDPOINT 4'd2

`endif

// File: common/telemetry_pkg.sv
`include "telemetry_consts.svh"

package telemetry_pkg;

  // Snapshot layout, msb first:
  // crc_error, err_code[2:0], dump, blk_index[2:0], ctl_state[3:0], phy_state[3:0]
  typedef logic [15:0] telem_word_t;

  // One byte on the outgoing stream
  typedef logic [7:0] telem_byte_t;

  // Occupancy of the FIFO, output register included
  typedef logic [`TELEM_FIFO_ABITS:0] fifo_level_t;

  // Position of a word inside its frame
  typedef logic [$clog2(`TELEM_FRAME_WORDS)-1:0] frame_index_t;

  // Which half of the held word goes out next
  typedef enum logic {
    SER_LOW  = 1'b0,
    SER_HIGH = 1'b1
  } ser_state_e;

endpackage

// File: design/telemetry_capture.sv
`timescale 1ns/100ps

`include "telemetry_consts.svh"

module telemetry_capture
  import telemetry_pkg::*;
(
  input  logic        clock,
  input  logic        reset,

  input  logic        usb_enum_i,
  input  logic        crc_error_i,
  input  logic        timeout_i,
  input  logic [3:0]  phy_state_i,
  input  logic [2:0]  usb_error_i,
  input  logic [3:0]  usb_state_i,
  input  logic [3:0]  ctl_state_i,
  input  logic [7:0]  blk_state_i,

  input  logic        push_ready_i,
  output logic        push_valid_o,
  output telem_word_t push_word_o,
  output logic        push_last_o
);

  logic [2:0]   err_code;
  logic         usb_dump;
  logic [2:0]   blk_index;
  telem_word_t  curr_word;
  telem_word_t  prev_word_q;
  frame_index_t frame_idx_q;
  logic         push_accept;

  // Compact codes from the raw status
  always_comb begin
    err_code = timeout_i ? 3'd7 : usb_error_i;
    usb_dump = (usb_state_i == 4'h8);

    // One-hot bulk state to an index, anything else is 7
    case (blk_state_i)
      8'h01:   blk_index = 3'd0;
      8'h02:   blk_index = 3'd1;
      8'h04:   blk_index = 3'd2;
      8'h08:   blk_index = 3'd3;
      8'h10:   blk_index = 3'd4;
      8'h20:   blk_index = 3'd5;
      8'h40:   blk_index = 3'd6;
      default: blk_index = 3'd7;
    endcase
  end

  assign curr_word = {crc_error_i, err_code, usb_dump, blk_index, ctl_state_i, phy_state_i};

  // Snapshot of the previous clock, taken whether or not it was pushed
  always_ff @(posedge clock) begin
    if (reset) begin
      prev_word_q <= '0;
    end else begin
      prev_word_q <= curr_word;
    end
  end

  assign push_valid_o = usb_enum_i && (curr_word != prev_word_q);
  assign push_word_o  = curr_word;
  assign push_accept  = push_valid_o && push_ready_i;

  // Frame position moves only when the FIFO takes the word
  always_ff @(posedge clock) begin
    if (reset) begin
      frame_idx_q <= '0;
    end else if (push_accept) begin
      if (frame_idx_q == frame_index_t'(`TELEM_FRAME_WORDS - 1)) begin
        frame_idx_q <= '0;
      end else begin
        frame_idx_q <= frame_idx_q + 1'b1;
      end
    end
  end

  assign push_last_o = (frame_idx_q == frame_index_t'(`TELEM_FRAME_WORDS - 1));

endmodule

// File: design/telemetry_fifo.sv
`timescale 1ns/100ps

`include "telemetry_consts.svh"

module telemetry_fifo
  import telemetry_pkg::*;
(
  input  logic        clock,
  input  logic        reset,

  input  logic        push_valid_i,
  input  telem_word_t push_word_i,
  input  logic        push_last_i,
  output logic        push_ready_o,

  input  logic        pop_ready_i,
  output logic        pop_valid_o,
  output telem_word_t pop_word_o,
  output logic        pop_last_o,

  output fifo_level_t level_o
);

  localparam int unsigned DEPTH = 1 << `TELEM_FIFO_ABITS;

  // Entry is the last flag on top of the word
  logic [16:0] mem [DEPTH];

  logic [`TELEM_FIFO_ABITS:0] wr_ptr_q;
  logic [`TELEM_FIFO_ABITS:0] rd_ptr_q;
  fifo_level_t                level_q;

  logic        out_valid_q;
  logic [16:0] out_entry_q;

  logic mem_empty;
  logic push_accept;
  logic pop_accept;
  logic out_load;

  assign mem_empty    = (wr_ptr_q == rd_ptr_q);
  assign push_ready_o = (level_q != fifo_level_t'(DEPTH));
  assign push_accept  = push_valid_i && push_ready_o;
  assign pop_accept   = out_valid_q && pop_ready_i;

  // Output stage refills when it is empty or being popped
  assign out_load = !mem_empty && (!out_valid_q || pop_ready_i);

  always_ff @(posedge clock) begin
    if (push_accept) begin
      mem[wr_ptr_q[`TELEM_FIFO_ABITS-1:0]] <= {push_last_i, push_word_i};
    end
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
    end else begin
      if (push_accept) begin
        wr_ptr_q <= wr_ptr_q + 1'b1;
      end
      if (out_load) begin
        rd_ptr_q <= rd_ptr_q + 1'b1;
      end
    end
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      out_valid_q <= 1'b0;
    end else if (out_load) begin
      out_valid_q <= 1'b1;
    end else if (pop_accept) begin
      out_valid_q <= 1'b0;
    end
  end

  always_ff @(posedge clock) begin
    if (out_load) begin
      out_entry_q <= mem[rd_ptr_q[`TELEM_FIFO_ABITS-1:0]];
    end
  end

  // Counts storage plus the output register
  always_ff @(posedge clock) begin
    if (reset) begin
      level_q <= '0;
    end else begin
      case ({push_accept, pop_accept})
        2'b10:   level_q <= level_q + 1'b1;
        2'b01:   level_q <= level_q - 1'b1;
        default: level_q <= level_q;
      endcase
    end
  end

  assign pop_valid_o = out_valid_q;
  assign pop_word_o  = out_entry_q[15:0];
  assign pop_last_o  = out_entry_q[16];
  assign level_o     = level_q;

endmodule

// File: design/byte_serializer.sv
`timescale 1ns/100ps

module byte_serializer
  import telemetry_pkg::*;
(
  input  logic        clock,
  input  logic        reset,

  input  logic        word_valid_i,
  input  telem_word_t word_i,
  input  logic        word_last_i,
  output logic        word_ready_o,

  input  logic        byte_ready_i,
  output logic        byte_valid_o,
  output telem_byte_t byte_o,
  output logic        byte_last_o
);

  ser_state_e  state_q;
  logic        valid_q;
  telem_byte_t byte_q;
  logic        last_q;
  telem_byte_t high_q;
  logic        word_last_q;
  logic        advance;

  // Output register can take a new byte
  assign advance      = !valid_q || byte_ready_i;
  assign word_ready_o = (state_q == SER_LOW) && advance;

  always_ff @(posedge clock) begin
    if (reset) begin
      state_q <= SER_LOW;
      valid_q <= 1'b0;
      last_q  <= 1'b0;
    end else if (advance) begin
      case (state_q)
        SER_LOW: begin
          valid_q <= word_valid_i;
          last_q  <= 1'b0;
          if (word_valid_i) begin
            state_q <= SER_HIGH;
          end
        end
        SER_HIGH: begin
          // Frame end only rides on the second byte
          valid_q <= 1'b1;
          last_q  <= word_last_q;
          state_q <= SER_LOW;
        end
        default: state_q <= SER_LOW;
      endcase
    end
  end

  always_ff @(posedge clock) begin
    if (advance) begin
      if (state_q == SER_LOW) begin
        byte_q      <= word_i[7:0];
        high_q      <= word_i[15:8];
        word_last_q <= word_last_i;
      end else begin
        byte_q <= high_q;
      end
    end
  end

  assign byte_valid_o = valid_q;
  assign byte_o       = byte_q;
  assign byte_last_o  = last_q;

endmodule

// File: design/bulk_telemetry.sv
`timescale 1ns/100ps

`include "telemetry_consts.svh"

module bulk_telemetry
  import telemetry_pkg::*;
#(
  parameter logic [3:0] ENDPOINT = `TELEM_DEFAULT_ENDPOINT
) (
  input  logic        clock,
  input  logic        reset,

  input  logic        usb_enum_i,
  input  logic        crc_error_i,
  input  logic        timeout_i,
  input  logic [3:0]  phy_state_i,
  input  logic [2:0]  usb_error_i,
  input  logic [3:0]  usb_state_i,
  input  logic [3:0]  ctl_state_i,
  input  logic [7:0]  blk_state_i,

  input  logic        select_i,
  input  logic        start_i,
  input  logic [3:0]  endpt_i,
  output fifo_level_t level_o,

  output logic        m_tvalid_o,
  input  logic        m_tready_i,
  output logic        m_tlast_o,
  output telem_byte_t m_tdata_o
);

  logic        push_valid;
  logic        push_ready;
  telem_word_t push_word;
  logic        push_last;

  logic        fifo_valid;
  logic        fifo_ready;
  telem_word_t fifo_word;
  logic        fifo_last;

  logic        ser_valid;
  logic        ser_ready;
  telem_byte_t ser_byte;
  logic        ser_last;

  logic        sel_q;

  // Host opened a transfer on our endpoint, held until the frame end goes out
  always_ff @(posedge clock) begin
    if (reset) begin
      sel_q <= 1'b0;
    end else if (usb_enum_i && start_i && select_i && (endpt_i == ENDPOINT)) begin
      sel_q <= 1'b1;
    end else if (m_tvalid_o && m_tready_i && m_tlast_o) begin
      sel_q <= 1'b0;
    end
  end

  assign m_tvalid_o = sel_q && ser_valid;
  assign ser_ready  = sel_q && m_tready_i;
  assign m_tlast_o  = ser_last;
  assign m_tdata_o  = ser_byte;

  telemetry_capture capture_i (
    .clock        (clock),
    .reset        (reset),
    .usb_enum_i   (usb_enum_i),
    .crc_error_i  (crc_error_i),
    .timeout_i    (timeout_i),
    .phy_state_i  (phy_state_i),
    .usb_error_i  (usb_error_i),
    .usb_state_i  (usb_state_i),
    .ctl_state_i  (ctl_state_i),
    .blk_state_i  (blk_state_i),
    .push_ready_i (push_ready),
    .push_valid_o (push_valid),
    .push_word_o  (push_word),
    .push_last_o  (push_last)
  );

  telemetry_fifo fifo_i (
    .clock        (clock),
    .reset        (reset),
    .push_valid_i (push_valid),
    .push_word_i  (push_word),
    .push_last_i  (push_last),
    .push_ready_o (push_ready),
    .pop_ready_i  (fifo_ready),
    .pop_valid_o  (fifo_valid),
    .pop_word_o   (fifo_word),
    .pop_last_o   (fifo_last),
    .level_o      (level_o)
  );

  byte_serializer serializer_i (
    .clock        (clock),
    .reset        (reset),
    .word_valid_i (fifo_valid),
    .word_i       (fifo_word),
    .word_last_i  (fifo_last),
    .word_ready_o (fifo_ready),
    .byte_ready_i (ser_ready),
    .byte_valid_o (ser_valid),
    .byte_o       (ser_byte),
    .byte_last_o  (ser_last)
  );

endmodule

// File: dv/tb_bulk_telemetry.sv
`timescale 1ns/100ps

`include "telemetry_consts.svh"

module tb_bulk_telemetry
  import telemetry_pkg::*;
();

  localparam int CAPACITY       = (1 << `TELEM_FIFO_ABITS) + 1;
  localparam int FRAME_LIMIT    = 300;
  localparam int RANDOM_CYCLES  = 2000;
  localparam int PLANNED_CYCLES = 200 + 8 * FRAME_LIMIT + RANDOM_CYCLES;

  logic        clock = 1'b0;
  logic        reset, usb_enum, crc_error, timeout;
  logic [3:0]  phy_state, usb_state, ctl_state, endpt;
  logic [2:0]  usb_error;
  logic [7:0]  blk_state;
  logic        select, start, m_tready, m_tvalid, m_tlast;
  telem_byte_t m_tdata;
  fifo_level_t level;

  integer       seed;
  int           errors, checks, in_flight, frames_done;
  string        test_name;
  telem_word_t  prev_word_m;
  frame_index_t frame_idx_m;
  logic         sel_m, high_next, stall_q;
  telem_byte_t  stall_data;
  telem_word_t  exp_words[$];
  logic         exp_lasts[$];

  bulk_telemetry bulk_telemetry_i (
    .clock       (clock),
    .reset       (reset),
    .usb_enum_i  (usb_enum),
    .crc_error_i (crc_error),
    .timeout_i   (timeout),
    .phy_state_i (phy_state),
    .usb_error_i (usb_error),
    .usb_state_i (usb_state),
    .ctl_state_i (ctl_state),
    .blk_state_i (blk_state),
    .select_i    (select),
    .start_i     (start),
    .endpt_i     (endpt),
    .level_o     (level),
    .m_tvalid_o  (m_tvalid),
    .m_tready_i  (m_tready),
    .m_tlast_o   (m_tlast),
    .m_tdata_o   (m_tdata)
  );

  always #2 clock = ~clock;

  function automatic telem_word_t pack_status();
    logic [2:0] code;
    logic [2:0] idx;
    int         ones;
    code = timeout ? 3'd7 : usb_error;
    idx  = 3'd7;
    ones = 0;
    for (int b = 0; b < 8; b++) begin
      if (blk_state[b]) begin
        ones++;
        idx = 3'(b);
      end
    end
    if (ones != 1) idx = 3'd7;
    return {crc_error, code, (usb_state == 4'd8), idx, ctl_state, phy_state};
  endfunction

  // The serializer grabs the first word even while the endpoint is closed
  function automatic int idle_level();
    return (in_flight > 0) ? in_flight - 1 : 0;
  endfunction

  function automatic logic frame_pending();
    foreach (exp_lasts[k]) begin
      if (exp_lasts[k]) begin
        return 1'b1;
      end
    end
    return 1'b0;
  endfunction

  // Reference model runs half a cycle before the edge it predicts
  always @(negedge clock) begin : model
    telem_word_t curr;
    logic        xfer, room;
    telem_byte_t exp_byte;
    logic        exp_last;
    if (reset) begin
      prev_word_m = '0;
      frame_idx_m = '0;
      in_flight   = 0;
      sel_m       = 1'b0;
      high_next   = 1'b0;
      stall_q     = 1'b0;
    end else begin
      curr = pack_status();
      xfer = m_tvalid && m_tready;
      room = in_flight < CAPACITY;
      checks += 2;
      if (m_tvalid && !sel_m) begin
        errors++;
        $display("error %s: expected m_tvalid_o 0, actual 1", test_name);
      end
      if (stall_q && (m_tvalid !== 1'b1 || m_tdata !== stall_data)) begin
        errors++;
        $display("error %s: expected held byte %h, actual %h", test_name, stall_data, m_tdata);
      end
      stall_q    = m_tvalid && !m_tready;
      stall_data = m_tdata;
      if (xfer) begin
        checks++;
        if (exp_words.size() == 0) begin
          errors++;
          $display("Byte %h left the DUT with no captured word to match", m_tdata);
        end else begin
          exp_byte = high_next ? exp_words[0][15:8] : exp_words[0][7:0];
          exp_last = high_next ? exp_lasts[0] : 1'b0;
          if (m_tdata !== exp_byte || m_tlast !== exp_last) begin
            errors++;
            $display("error %s: expected byte %h last %b, actual byte %h last %b",
                     test_name, exp_byte, exp_last, m_tdata, m_tlast);
          end
          if (high_next) begin
            void'(exp_words.pop_front());
            void'(exp_lasts.pop_front());
            in_flight--;
          end
          high_next = !high_next;
        end
        if (m_tlast) frames_done++;
      end
      // A full buffer loses the word and the frame position stays put
      if (usb_enum && curr != prev_word_m && room) begin
        exp_words.push_back(curr);
        exp_lasts.push_back(frame_idx_m == frame_index_t'(`TELEM_FRAME_WORDS - 1));
        frame_idx_m = frame_index_t'((int'(frame_idx_m) + 1) % `TELEM_FRAME_WORDS);
        in_flight++;
      end
      if (usb_enum && start && select && endpt == `TELEM_DEFAULT_ENDPOINT) sel_m = 1'b1;
      else if (xfer && m_tlast) sel_m = 1'b0;
      prev_word_m = curr;
    end
  end

  task automatic step();
    @(posedge clock);
    #1;
  endtask

  task automatic check_level(input int expected);
    checks++;
    if (level !== fifo_level_t'(expected)) begin
      errors++;
      $display("error %s: expected level %0d, actual %0d", test_name, expected, level);
    end
  endtask

  task automatic random_status();
    int pick;
    if (($random(seed) & 3) == 0) begin
      pick = ($random(seed) & 32'h7fff_ffff) % 7;
      case (pick)
        0: phy_state = 4'($random(seed));
        1: ctl_state = 4'($random(seed));
        2: usb_state = ($random(seed) & 1) ? 4'd8 : 4'($random(seed));
        3: usb_error = 3'($random(seed));
        4: timeout = !timeout;
        5: crc_error = !crc_error;
        default: blk_state = ($random(seed) & 1) ? 8'(1 << ($random(seed) & 7)) : 8'($random(seed));
      endcase
    end
  endtask

  task automatic open_endpoint(input logic [3:0] ep);
    step();
    select = 1'b1;
    start  = 1'b1;
    endpt  = ep;
    step();
    select = 1'b0;
    start  = 1'b0;
  endtask

  task automatic wait_frames(input int target);
    int waited;
    waited = 0;
    while (frames_done < target && waited < FRAME_LIMIT) begin
      step();
      waited++;
    end
    if (frames_done < target) begin
      errors++;
      $display("No frame end arrived within %0d cycles in test %s", FRAME_LIMIT, test_name);
    end
  endtask

  initial begin
    seed        = 76;
    errors      = 0;
    checks      = 0;
    frames_done = 0;
    test_name   = "reset";
    reset       = 1'b1;
    usb_enum    = 1'b0;
    crc_error   = 1'b0;
    timeout     = 1'b0;
    phy_state   = '0;
    usb_state   = '0;
    ctl_state   = '0;
    usb_error   = '0;
    blk_state   = '0;
    select      = 1'b0;
    start       = 1'b0;
    endpt       = '0;
    m_tready    = 1'b1;
    repeat (3) @(posedge clock);
    #1;
    reset = 1'b0;
    step();
    check_level(0);

    test_name = "enum_off";
    repeat (60) begin
      step();
      random_status();
    end
    repeat (4) step();
    check_level(0);

    test_name = "capture";
    usb_enum = 1'b1;
    for (int k = 0; k < 5; k++) begin
      step();
      case (k)
        0: timeout = 1'b1;
        1: usb_state = 4'd8;
        2: blk_state = 8'h10;
        3: blk_state = 8'h24;
        default: crc_error = 1'b1;
      endcase
      repeat (4) step();
      check_level(idle_level());
    end

    test_name = "fill";
    repeat (30) begin
      step();
      phy_state = phy_state + 4'd1;
    end
    repeat (4) step();
    check_level(1 << `TELEM_FIFO_ABITS);

    test_name = "endpoint";
    open_endpoint(4'd5);
    repeat (12) step();
    open_endpoint(`TELEM_DEFAULT_ENDPOINT);
    wait_frames(1);
    repeat (6) step();
    open_endpoint(`TELEM_DEFAULT_ENDPOINT);
    wait_frames(2);
    repeat (9) begin
      step();
      ctl_state = ctl_state + 4'd1;
    end
    open_endpoint(`TELEM_DEFAULT_ENDPOINT);
    wait_frames(3);

    test_name = "random";
    repeat (RANDOM_CYCLES) begin
      step();
      random_status();
      m_tready = 1'($random(seed));
      select   = 1'b0;
      start    = 1'b0;
      if (!sel_m && ($random(seed) & 7) == 0) begin
        select = 1'b1;
        start  = 1'b1;
        endpt  = ($random(seed) & 1) ? `TELEM_DEFAULT_ENDPOINT : 4'($random(seed));
      end
    end

    test_name = "drain";
    step();
    m_tready = 1'b1;
    select   = 1'b0;
    start    = 1'b0;
    for (int k = 0; k < 4 && frame_pending(); k++) begin
      open_endpoint(`TELEM_DEFAULT_ENDPOINT);
      wait_frames(frames_done + 1);
    end
    checks++;
    if (frame_pending()) begin
      errors++;
      $display("Complete frames were still waiting in the DUT after the drain");
    end

    $display("Checks: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("Regression passed");
    end else begin
      $display("Regression failed");
    end
    $finish;
  end

  initial begin
    #(PLANNED_CYCLES * 200 + 2000);
    $display("Watchdog expired before the tests finished, checks: %0d, errors: %0d",
             checks, errors);
    $display("Regression failed");
    $finish;
  end

endmodule

// File: tb.f
+incdir+common
common/telemetry_pkg.sv
design/telemetry_capture.sv
design/telemetry_fifo.sv
design/byte_serializer.sv
design/bulk_telemetry.sv
dv/tb_bulk_telemetry.sv

// File: run.sh
#!/usr/bin/env bash
# Builds the testbench with Verilator and runs it

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -Wno-fatal -f tb.f \
  --top-module tb_bulk_telemetry -o sim_bulk_telemetry
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

sim_output=$(./obj_dir/sim_bulk_telemetry)
sim_status=$?
echo "$sim_output"

if [ $sim_status -ne 0 ]; then
  echo "Simulation exited with status $sim_status"
  exit 1
fi

if echo "$sim_output" | grep -qx "Regression passed"; then
  exit 0
fi

echo "Pass message not found in simulation output"
exit 1
